// File: sim.f
+incdir+source
source/rv_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/rv_core_top.sv
tb/tb_clock_gen.sv
tb/tb_core.sv

// File: tb/tb_core.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_core import rv_pkg::*; ();

  localparam word_t NOP = 32'h0000_0013;  // addi x0, x0, 0
  localparam int WAIT_LIMIT = 50;

  typedef struct packed {
    word_t      inst;
    word_t      rdata;
    word_t      pc;
    logic       rd;
    logic       wr;
    word_t      addr;
    word_t      wdata;
    byte_mask_t mask;
    logic       halt;
  } row_t;

  logic       clk;
  logic       reset;
  word_t      inst;
  word_t      mem_rdata;
  word_t      pc;
  word_t      mem_addr;
  word_t      mem_wdata;
  byte_mask_t mem_wmask;
  logic       mem_read;
  logic       mem_write;
  logic       halted;

  row_t   rows[$];
  word_t  shadow [0:31];  // expected register contents
  word_t  exp_pc;
  logic   exp_halt;
  integer seed = 32'h699c8c0d;
  int     halt_row;

  tb_clock_gen u_clk (.clk(clk), .reset(reset));

  rv_core_top uut (
    .clk       (clk),
    .reset     (reset),
    .inst      (inst),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .halted    (halted)
  );

  task automatic stop_with(string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t exp, word_t got);
    if (got !== exp) begin
      $display("Error %s expected %h got %h", name, exp, got);
      stop_with("value mismatch");
    end
  endtask

  task automatic check_mask(string name, byte_mask_t exp, byte_mask_t got);
    if (got !== exp) begin
      $display("Error %s expected %h got %h", name, exp, got);
      stop_with("value mismatch");
    end
  endtask

  task automatic check_bit(string name, logic exp, logic got);
    if (got !== exp) begin
      $display("Error %s expected %h got %h", name, exp, got);
      stop_with("value mismatch");
    end
  endtask

  // RV32I instruction encoders
  function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b010_0011};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_j(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b110_1111};
  endfunction

  // value a load leaves in rd, per the RV32I extension rules
  function automatic word_t load_value(logic [2:0] f3, logic [1:0] off, word_t raw);
    word_t lane;
    lane = raw >> (8 * off);
    case (f3)
      3'b000:  return {{24{lane[7]}}, lane[7:0]};
      3'b001:  return {{16{lane[15]}}, lane[15:0]};
      3'b100:  return {24'h00_0000, lane[7:0]};
      3'b101:  return {16'h0000, lane[15:0]};
      default: return lane;
    endcase
  endfunction

  // bytes off .. off+size-1, none for a misaligned access
  function automatic byte_mask_t store_lanes(int size, int off);
    byte_mask_t m;
    m = '0;
    if ((off % size) == 0) begin
      for (int b = 0; b < 4; b++) begin
        m[b] = (b >= off) && (b < off + size);
      end
    end
    return m;
  endfunction

  task automatic add_row(word_t i, word_t rdata, logic rd, logic wr, word_t addr,
                         word_t wdata, byte_mask_t mask);
    row_t r;
    r.inst  = i;
    r.rdata = rdata;
    r.pc    = exp_pc;
    r.rd    = rd;
    r.wr    = wr;
    r.addr  = addr;
    r.wdata = wdata;
    r.mask  = mask;
    r.halt  = exp_halt;
    rows.push_back(r);
    if (!exp_halt) exp_pc = exp_pc + `RV_INST_STEP;
  endtask

  task automatic add_plain(word_t i);
    add_row(i, '0, 1'b0, 1'b0, '0, '0, '0);
  endtask

  // sw rN, 0(x5) makes a register visible on the memory port
  task automatic show_reg(reg_idx_t r);
    add_row(enc_s(12'd0, r, 5'd5, w_word), '0, 1'b0, 1'b1, shadow[5], shadow[r], 4'hf);
  endtask

  task automatic store_row(logic [2:0] f3, int off, byte_mask_t mask, word_t wdata);
    add_row(enc_s(off[11:0], 5'd3, 5'd5, f3), '0, 1'b0, mask != '0, shadow[5] + off,
            wdata, mask);
  endtask

  task automatic load_offsets(logic [2:0] f3, int step);
    word_t raw;
    for (int off = 0; off < 4; off += step) begin
      raw = $random(seed);
      add_row(enc_i(off[11:0], 5'd5, f3, 5'd6, op_load), raw, 1'b1, 1'b0,
              shadow[5] + off, '0, '0);
      shadow[6] = load_value(f3, off[1:0], raw);
      show_reg(5'd6);
    end
  endtask

  task automatic build_rows();
    word_t jump_from;
    exp_pc    = `RV_RESET_PC;
    exp_halt  = 1'b0;
    shadow[0] = '0;
    add_plain(NOP);
    shadow[1] = 32'h0000_0123;
    add_plain(enc_i(12'h123, 5'd0, 3'b000, 5'd1, op_imm));
    shadow[2] = shadow[1] - 32'd5;
    add_plain(enc_i(12'hffb, 5'd1, 3'b000, 5'd2, op_imm));
    shadow[3] = 32'habcd_e000;
    add_plain(enc_u(20'habcde, 5'd3, op_lui));
    shadow[3] = shadow[3] + 32'h765;
    add_plain(enc_i(12'h765, 5'd3, 3'b000, 5'd3, op_imm));
    shadow[4] = exp_pc + 32'h0001_2000;
    add_plain(enc_u(20'h00012, 5'd4, op_auipc));
    add_plain(enc_i(12'h007, 5'd1, 3'b000, 5'd0, op_imm));  // x0 stays zero
    add_plain(32'h0010_80b3);  // add x1, x1, x1 is not decoded
    shadow[5] = 32'h1000_0000;  // data base
    add_plain(enc_u(20'h10000, 5'd5, op_lui));
    for (int r = 0; r < 5; r++) show_reg(r[4:0]);
    load_offsets(w_byte, 1);
    load_offsets(w_half, 2);
    load_offsets(w_word, 4);
    load_offsets(w_byte_u, 1);
    load_offsets(w_half_u, 2);
    for (int off = 0; off < 4; off++) begin
      store_row(w_byte, off, store_lanes(1, off), {4{shadow[3][7:0]}});
      store_row(w_half, off, store_lanes(2, off), {2{shadow[3][15:0]}});
      store_row(w_word, off, store_lanes(4, off), shadow[3]);
    end
    jump_from = exp_pc;
    shadow[7] = jump_from + `RV_INST_STEP;
    add_plain(enc_j(21'd16, 5'd7));
    exp_pc    = jump_from + 32'd16;
    shadow[9] = exp_pc;
    add_plain(enc_u(20'h00000, 5'd9, op_auipc));
    shadow[8] = exp_pc + `RV_INST_STEP;
    add_plain(enc_i(12'h021, 5'd9, 3'b000, 5'd8, op_jalr));
    exp_pc = (shadow[9] + 32'h21) & ~32'h1;  // odd target, bit 0 cleared
    show_reg(5'd7);
    show_reg(5'd8);
    add_plain(32'h0010_0073);  // ebreak
    halt_row = rows.size() - 1;
    exp_pc   = exp_pc - `RV_INST_STEP;
    exp_halt = 1'b1;
    add_row(enc_s(12'd0, 5'd1, 5'd5, w_word), '0, 1'b0, 1'b0, '0, '0, '0);
    add_plain(NOP);
    add_plain(enc_j(21'd64, 5'd1));  // no redirect once halted
  endtask

  // drive at edge + 1 ns, sample 2 ns before the next edge
  task automatic apply_row(row_t r);
    inst      = r.inst;
    mem_rdata = r.rdata;
    #17;
    check_word("pc", r.pc, pc);
    check_bit("mem_read", r.rd, mem_read);
    check_bit("mem_write", r.wr, mem_write);
    check_mask("mem_wmask", r.mask, mem_wmask);
    check_bit("halted", r.halt, halted);
    if (r.rd || r.wr) check_word("mem_addr", r.addr, mem_addr);
    if (r.wr) check_word("mem_wdata", r.wdata, mem_wdata);
    @(posedge clk);
    #1;
  endtask

  initial begin
    int waited;
    inst      = NOP;
    mem_rdata = '0;
    build_rows();
    waited = 0;
    do begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) stop_with("reset was never released");
    end while (reset);
    check_word("pc", `RV_RESET_PC, pc);
    check_bit("mem_read", 1'b0, mem_read);
    check_bit("mem_write", 1'b0, mem_write);
    check_bit("halted", 1'b0, halted);
    for (int i = 0; i <= halt_row; i++) apply_row(rows[i]);
    waited = 0;
    while (!halted) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) stop_with("core did not halt after ebreak");
    end
    for (int i = halt_row + 1; i < rows.size(); i++) apply_row(rows[i]);
    $display("TEST OK");
    $finish;
  end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  localparam int HALF_PERIOD = 10;  // 20 ns clock
  localparam int RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // released with the last reset edge so the core still sees it high there
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: source/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  word_t      inst,
  input  word_t      mem_rdata,
  output word_t      pc,
  output word_t      mem_addr,
  output word_t      mem_wdata,
  output byte_mask_t mem_wmask,
  output logic       mem_read,
  output logic       mem_write,
  output logic       halted
);

  word_t      pc_next_seq;
  word_t      jump_target;
  opcode_e    opcode;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  mem_width_e width;
  word_t      imm;
  opa_sel_e   opa_sel;
  wb_sel_e    wb_sel;
  logic       reg_write;
  logic       is_load;
  logic       is_store;
  logic       is_jump;
  logic       is_ebreak;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      sum;
  word_t      wb_data;
  logic       wb_enable;

  fetch_stage u_fetch (
    .clk         (clk),
    .reset       (reset),
    .is_jump     (is_jump),
    .is_ebreak   (is_ebreak),
    .jump_target (jump_target),
    .pc          (pc),
    .pc_next_seq (pc_next_seq),
    .halted      (halted)
  );

  decode_stage u_decode (
    .inst      (inst),
    .opcode    (opcode),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .width     (width),
    .imm       (imm),
    .opa_sel   (opa_sel),
    .wb_sel    (wb_sel),
    .reg_write (reg_write),
    .is_load   (is_load),
    .is_store  (is_store),
    .is_jump   (is_jump),
    .is_ebreak (is_ebreak)
  );

  register_file u_regfile (
    .clk       (clk),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .wb_enable (wb_enable),
    .wb_data   (wb_data),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

  execute_stage u_execute (
    .opa_sel     (opa_sel),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .imm         (imm),
    .opcode      (opcode),
    .sum         (sum),
    .jump_target (jump_target)
  );

  mem_wb_stage u_mem_wb (
    .halted      (halted),
    .is_load     (is_load),
    .is_store    (is_store),
    .reg_write   (reg_write),
    .width       (width),
    .wb_sel      (wb_sel),
    .sum         (sum),
    .rs2_data    (rs2_data),
    .pc_next_seq (pc_next_seq),
    .mem_rdata   (mem_rdata),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .wb_data     (wb_data),
    .mem_wmask   (mem_wmask),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .wb_enable   (wb_enable)
  );

endmodule

// File: source/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage import rv_pkg::*; (
  input  logic       halted,
  input  logic       is_load,
  input  logic       is_store,
  input  logic       reg_write,
  input  mem_width_e width,
  input  wb_sel_e    wb_sel,
  input  word_t      sum,
  input  word_t      rs2_data,
  input  word_t      pc_next_seq,
  input  word_t      mem_rdata,
  output word_t      mem_addr,
  output word_t      mem_wdata,
  output word_t      wb_data,
  output byte_mask_t mem_wmask,
  output logic       mem_read,
  output logic       mem_write,
  output logic       wb_enable
);

  logic [1:0] offset;
  logic       aligned;
  byte_mask_t lane_mask;
  word_t      lane_data;
  word_t      load_data;

  assign mem_addr = sum;
  assign offset   = sum[1:0];

  // legal width with natural alignment
  always_comb begin
    case (width)
      w_byte, w_byte_u: aligned = 1'b1;
      w_half, w_half_u: aligned = ~offset[0];
      w_word:           aligned = (offset == 2'b00);
      default:          aligned = 1'b0;
    endcase
    if (is_store && ((width == w_byte_u) || (width == w_half_u))) begin
      aligned = 1'b0;  // no unsigned store forms
    end
  end

  always_comb begin
    case (width)
      w_byte, w_byte_u: lane_mask = 4'b0001 << offset;
      w_half, w_half_u: lane_mask = offset[0] ? 4'b0000 : (4'b0011 << offset);
      w_word:           lane_mask = (offset == 2'b00) ? 4'b1111 : 4'b0000;
      default:          lane_mask = '0;
    endcase
  end

  assign mem_read  = is_load & aligned;
  assign mem_write = is_store & aligned & ~halted;
  assign mem_wmask = mem_write ? lane_mask : '0;

  // store data copied onto every lane, mask picks the right one
  always_comb begin
    case (width)
      w_byte:  mem_wdata = {4{rs2_data[7:0]}};
      w_half:  mem_wdata = {2{rs2_data[15:0]}};
      default: mem_wdata = rs2_data;
    endcase
  end

  // addressed byte moved down to bit 0
  assign lane_data = mem_rdata >> {offset, 3'b000};

  always_comb begin
    case (width)
      w_byte:   load_data = {{24{lane_data[7]}}, lane_data[7:0]};
      w_half:   load_data = {{16{lane_data[15]}}, lane_data[15:0]};
      w_word:   load_data = lane_data;
      w_byte_u: load_data = {24'h00_0000, lane_data[7:0]};
      w_half_u: load_data = {16'h0000, lane_data[15:0]};
      default:  load_data = '0;
    endcase
  end

  always_comb begin
    case (wb_sel)
      wb_link: wb_data = pc_next_seq;
      wb_load: wb_data = load_data;
      default: wb_data = sum;
    endcase
  end

  // a load that never reached memory leaves rd alone
  assign wb_enable = reg_write & ~halted & ~(is_load & ~aligned);

  // alignment check and lane table must agree
  wmask_nonzero: assert final (!mem_write || (mem_wmask != '0));

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
  input  opa_sel_e opa_sel,
  input  word_t    pc,
  input  word_t    rs1_data,
  input  word_t    imm,
  input  opcode_e  opcode,
  output word_t    sum,
  output word_t    jump_target
);

  word_t operand_a;

  // rs1 for addi/jalr/load/store, pc for auipc/jal, zero for lui
  always_comb begin
    case (opa_sel)
      opa_rs1: operand_a = rs1_data;
      opa_pc:  operand_a = pc;
      default: operand_a = '0;
    endcase
  end

  // one adder serves results, addresses and targets
  assign sum = operand_a + imm;

  always_comb begin
    if (opcode == op_jalr) begin
      jump_target = {sum[$bits(word_t)-1:1], 1'b0};  // lsb dropped
    end else begin
      jump_target = sum;
    end
  end

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module register_file import rv_pkg::*; (
  input  logic     clk,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  logic     wb_enable,
  input  word_t    wb_data,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  localparam int NUM_REGS = 1 << `RV_REG_AW;

  // x0 has no storage
  word_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (wb_enable && (rd != '0)) begin
      regs[rd] <= wb_data;
    end
  end

  // asynchronous reads, x0 reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
  input  word_t      inst,
  output opcode_e    opcode,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  output reg_idx_t   rd,
  output mem_width_e width,
  output word_t      imm,
  output opa_sel_e   opa_sel,
  output wb_sel_e    wb_sel,
  output logic       reg_write,
  output logic       is_load,
  output logic       is_store,
  output logic       is_jump,
  output logic       is_ebreak
);

  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_j;
  word_t      imm_u;

  assign opcode = opcode_e'(inst[6:0]);
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign width  = mem_width_e'(funct3);

  // immediate formats, all sign extended from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};

  always_comb begin
    // anything not listed below retires as a no-op
    imm       = '0;
    opa_sel   = opa_zero;
    wb_sel    = wb_sum;
    reg_write = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_jump   = 1'b0;
    is_ebreak = 1'b0;
    case (opcode)
      op_imm: begin
        if (funct3 == 3'b000) begin  // addi only
          imm       = imm_i;
          opa_sel   = opa_rs1;
          reg_write = 1'b1;
        end
      end
      op_lui: begin
        imm       = imm_u;
        reg_write = 1'b1;
      end
      op_auipc: begin
        imm       = imm_u;
        opa_sel   = opa_pc;
        reg_write = 1'b1;
      end
      op_jal: begin
        imm       = imm_j;
        opa_sel   = opa_pc;
        wb_sel    = wb_link;
        reg_write = 1'b1;
        is_jump   = 1'b1;
      end
      op_jalr: begin
        imm       = imm_i;
        opa_sel   = opa_rs1;
        wb_sel    = wb_link;
        reg_write = 1'b1;
        is_jump   = 1'b1;
      end
      op_load: begin
        imm       = imm_i;
        opa_sel   = opa_rs1;
        wb_sel    = wb_load;
        reg_write = 1'b1;
        is_load   = 1'b1;
      end
      op_store: begin
        imm      = imm_s;
        opa_sel  = opa_rs1;
        is_store = 1'b1;
      end
      op_system: begin
        // exact ebreak encoding, other system ops ignored
        is_ebreak = (inst[31:20] == 12'h001) && (rs1 == '0) &&
                    (funct3 == 3'b000) && (rd == '0);
      end
      default: ;
    endcase
  end

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module fetch_stage import rv_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  is_jump,
  input  logic  is_ebreak,
  input  word_t jump_target,
  output word_t pc,
  output word_t pc_next_seq,
  output logic  halted
);

  word_t pc_next;

  assign pc_next_seq = pc + `RV_INST_STEP;
  assign pc_next     = is_jump ? jump_target : pc_next_seq;  // jal/jalr redirect

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= `RV_RESET_PC;
      halted <= 1'b0;
    end else if (!halted) begin
      if (is_ebreak) begin
        halted <= 1'b1;  // pc stays on the ebreak
      end else begin
        pc <= pc_next;
      end
    end
  end

  // once set, only reset clears the halt flag
  halt_sticky: assert property (
    @(posedge clk) $fell(halted) |-> $past(reset)
  );

  // a halted core does not fetch anything new
  pc_frozen: assert property (
    @(posedge clk) (halted && !reset) |=> $stable(pc)
  );

endmodule

// File: source/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]   word_t;
  typedef logic [`RV_REG_AW-1:0] reg_idx_t;
  typedef logic [`RV_XLEN/8-1:0] byte_mask_t;  // one bit per byte lane

  // RV32I major opcodes kept by this core
  typedef enum logic [6:0] {
    op_load   = 7'b000_0011,
    op_imm    = 7'b001_0011,
    op_auipc  = 7'b001_0111,
    op_store  = 7'b010_0011,
    op_lui    = 7'b011_0111,
    op_jalr   = 7'b110_0111,
    op_jal    = 7'b110_1111,
    op_system = 7'b111_0011
  } opcode_e;

  // funct3 of loads and stores
  typedef enum logic [2:0] {
    w_byte   = 3'b000,
    w_half   = 3'b001,
    w_word   = 3'b010,
    w_byte_u = 3'b100,
    w_half_u = 3'b101
  } mem_width_e;

  typedef enum logic [1:0] {
    wb_sum  = 2'd0,  // adder result
    wb_link = 2'd1,  // pc + 4
    wb_load = 2'd2
  } wb_sel_e;

  typedef enum logic [1:0] {
    opa_rs1  = 2'd0,
    opa_pc   = 2'd1,
    opa_zero = 2'd2
  } opa_sel_e;

endpackage

// File: source/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data, address and instruction width
`define RV_XLEN 32

// register index width, 32 architectural registers
`define RV_REG_AW 5

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000
`define RV_INST_STEP 32'd4

`endif
